//--- all.f
+incdir+common
common/kbd_pkg.sv
common/kbd_if.sv
ps2_receiver/ps2_receiver.sv
design/key_fifo.sv
design/key_bus_port.sv
design/keyboard_on_board.sv
tests/tb_clock.sv
tests/tb_keyboard.sv

//--- Makefile
TOP := tb_keyboard
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f all.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "STATUS: PASS" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

//--- tests/tb_keyboard.sv
`timescale 1ns/1ns
`include "kbd_config.svh"

module tb_keyboard;
    localparam int DEPTH       = `KEY_FIFO_DEPTH;
    localparam int BIT_CYCLES  = 20;
    localparam int POLL_LIMIT  = 200;
    // Frames sent by tests 1 to 5
    localparam int FRAME_COUNT = 20 + 7 + 3 + 2 + (DEPTH + 2);
    localparam int FRAME_NS    = 11 * BIT_CYCLES * 10;
    localparam int WATCHDOG_NS = FRAME_COUNT * FRAME_NS * 3 / 2 + 20000;

    logic        CLOCK_50;
    logic        KEY0;
    logic        ps2_clk;
    logic        ps2_dat;
    logic [63:0] bus_address;
    logic        bus_read_enable;
    logic [63:0] bus_read_data;
    logic [3:0]  interrupt_vector;
    logic        interrupt_ack;

    // Expected queue contents as {extended, break, code}
    logic [9:0]  model_q[$];
    bit          model_ovf;
    int          model_errs;
    int          test_num;
    int          test_errors;
    int          total_errors;
    int          tests_failed;
    int          checks;

    tb_clock u_clk (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0)
    );

    keyboard_on_board u_dut (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .ps2_clk          (ps2_clk),
        .ps2_dat          (ps2_dat),
        .bus_address      (bus_address),
        .bus_read_enable  (bus_read_enable),
        .bus_read_data    (bus_read_data),
        .interrupt_vector (interrupt_vector),
        .interrupt_ack    (interrupt_ack)
    );

    function automatic logic [63:0] expected_data(input logic valid, input logic [7:0] code,
                                                   input logic brk, input logic ext);
        logic [63:0] w;
        w = '0;
        if (valid) begin
            w[31]  = 1'b1;
            w[9]   = ext;
            w[8]   = brk;
            w[7:0] = code;
        end
        return w;
    endfunction

    function automatic logic [63:0] expected_status(input logic [3:0] count, input logic ovf,
                                                     input logic [7:0] errs);
        logic [63:0] w;
        w        = '0;
        w[3:0]   = count;
        w[8]     = ovf;
        w[23:16] = errs;
        return w;
    endfunction

    // Any byte except the two prefixes
    function automatic logic [7:0] random_code();
        logic [7:0] c;
        do begin
            c = 8'($urandom);
        end while (c == 8'hE0 || c == 8'hF0);
        return c;
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            test_errors++;
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic note_error(input string msg);
        test_errors++;
        $display("Error: %s", msg);
    endtask

    task automatic end_test(input string name);
        if (test_errors == 0) begin
            $display("Test %0d %s: ok", test_num, name);
        end else begin
            $display("Test %0d %s: %0d errors", test_num, name, test_errors);
            tests_failed++;
        end
        total_errors += test_errors;
        test_errors = 0;
        test_num++;
    endtask

    // Start bit, 8 data bits LSB first, odd parity, stop bit, then a quiet gap
    task automatic send_frame(input logic [7:0] code, input logic bad_parity);
        logic [10:0] bits;
        logic        parity;
        int          i;
        parity = ~^code;
        if (bad_parity) begin
            parity = ~parity;
        end
        bits = {1'b1, parity, code, 1'b0};
        for (i = 0; i < 11; i++) begin
            @(posedge CLOCK_50);
            ps2_dat <= bits[i];
            repeat (5) @(posedge CLOCK_50);
            ps2_clk <= 1'b0;
            repeat (10) @(posedge CLOCK_50);
            ps2_clk <= 1'b1;
            repeat (4) @(posedge CLOCK_50);
        end
        @(posedge CLOCK_50);
        ps2_dat <= 1'b1;
        repeat (BIT_CYCLES) @(posedge CLOCK_50);
    endtask

    // Sends the prefixes and the code and mirrors the FIFO in the model
    task automatic send_key(input logic [7:0] code, input logic brk, input logic ext);
        if (ext) begin
            send_frame(8'hE0, 1'b0);
        end
        if (brk) begin
            send_frame(8'hF0, 1'b0);
        end
        send_frame(code, 1'b0);
        if (model_q.size() < DEPTH) begin
            model_q.push_back({ext, brk, code});
        end else begin
            model_ovf = 1'b1;
        end
    endtask

    task automatic read_bus(input logic [63:0] addr, output logic [63:0] got);
        @(posedge CLOCK_50);
        bus_address     <= addr;
        bus_read_enable <= 1'b1;
        @(posedge CLOCK_50);
        bus_read_enable <= 1'b0;
        @(negedge CLOCK_50);
        got = bus_read_data;
    endtask

    task automatic pulse_ack();
        @(posedge CLOCK_50);
        interrupt_ack <= 1'b1;
        @(posedge CLOCK_50);
        interrupt_ack <= 1'b0;
        @(negedge CLOCK_50);
    endtask

    // Poll the status word until count and error fields match
    task automatic wait_status(input int exp_count, input int exp_errs);
        logic [63:0] word;
        int          polls;
        bit          done;
        done  = 1'b0;
        polls = 0;
        while (!done && polls < POLL_LIMIT) begin
            read_bus(`KEY_STAT_ADDR, word);
            model_ovf = 1'b0;
            if (word[3:0] == exp_count[3:0] && word[23:16] == exp_errs[7:0]) begin
                done = 1'b1;
            end
            polls++;
        end
        if (!done) begin
            note_error($sformatf("status never reached count %0d with %0d frame errors",
                                 exp_count, exp_errs));
        end
    endtask

    task automatic read_and_check_key();
        logic [63:0] got;
        logic [9:0]  entry;
        read_bus(`KEY_DATA_ADDR, got);
        if (model_q.size() == 0) begin
            check("bus_read_data", got, expected_data(1'b0, 8'h00, 1'b0, 1'b0));
        end else begin
            entry = model_q.pop_front();
            check("bus_read_data", got, expected_data(1'b1, entry[7:0], entry[8], entry[9]));
        end
    endtask

    task automatic read_and_check_status();
        logic [63:0] got;
        read_bus(`KEY_STAT_ADDR, got);
        check("bus_read_data (status)", got,
              expected_status(4'(model_q.size()), model_ovf, 8'(model_errs)));
        model_ovf = 1'b0;
    endtask

    task automatic check_vector(input logic [3:0] exp);
        check("interrupt_vector", 64'(interrupt_vector), 64'(exp));
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        logic [63:0] got;
        int          i;
        int          n;
        bit          seen;

        ps2_clk         <= 1'b1;
        ps2_dat         <= 1'b1;
        bus_address     <= '0;
        bus_read_enable <= 1'b0;
        interrupt_ack   <= 1'b0;
        model_ovf    = 1'b0;
        model_errs   = 0;
        test_num     = 1;
        test_errors  = 0;
        total_errors = 0;
        tests_failed = 0;
        checks       = 0;
        void'($urandom(32'h2b56_dc58));
        wait (KEY0 === 1'b1);
        repeat (2) @(posedge CLOCK_50);

        for (i = 0; i < 20; i++) begin
            send_key(random_code(), 1'b0, 1'b0);
            wait_status(1, model_errs);
            read_and_check_key();
        end
        end_test("random make codes");

        // Break, extended, extended break
        for (i = 0; i < 3; i++) begin
            send_key(random_code(), i != 1, i != 0);
            wait_status(1, model_errs);
            read_and_check_status();
            read_and_check_key();
        end
        end_test("prefix folding");

        send_frame(8'hE0, 1'b0);
        send_frame(random_code(), 1'b1);
        model_errs++;
        wait_status(0, model_errs);
        read_and_check_status();
        send_key(random_code(), 1'b0, 1'b0);
        wait_status(1, model_errs);
        read_and_check_key();
        end_test("parity error");

        pulse_ack();
        check_vector(4'd0);
        send_key(random_code(), 1'b0, 1'b0);
        seen = 1'b0;
        for (n = 0; n < POLL_LIMIT && !seen; n++) begin
            @(negedge CLOCK_50);
            seen = (interrupt_vector != 4'd0);
        end
        if (!seen) begin
            note_error("interrupt_vector never rose after a key arrived");
        end
        for (n = 0; n < 10; n++) begin
            @(negedge CLOCK_50);
            check_vector(4'd1);
        end
        pulse_ack();
        check_vector(4'd0);
        send_key(random_code(), 1'b0, 1'b0);
        wait_status(2, model_errs);
        check_vector(4'd0);
        // Read leaves one key behind
        read_and_check_key();
        check_vector(4'd1);
        pulse_ack();
        check_vector(4'd0);
        read_and_check_key();
        for (n = 0; n < 5; n++) begin
            @(negedge CLOCK_50);
            check_vector(4'd0);
        end
        end_test("interrupt vector");

        // The last two keys find the queue full
        for (i = 0; i < DEPTH + 2; i++) begin
            send_key(random_code(), 1'b0, 1'b0);
            if (i < DEPTH) begin
                wait_status(i + 1, model_errs);
            end
        end
        read_and_check_status();
        read_and_check_status();
        for (i = 0; i < DEPTH; i++) begin
            read_and_check_key();
        end
        end_test("overflow");

        read_and_check_key();
        read_and_check_status();
        read_bus(64'h1000_0010, got);
        check("bus_read_data (unmapped)", got, 64'h0);
        read_bus(64'h0, got);
        check("bus_read_data (unmapped)", got, 64'h0);
        end_test("empty and unmapped reads");

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 test_num - 1, tests_failed, checks, total_errors);
        if (total_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/1ns

// Board clock and power-on reset
module tb_clock (
    output logic CLOCK_50,
    output logic KEY0
);
    initial begin
        CLOCK_50 = 1'b0;
        forever begin
            #5 CLOCK_50 = ~CLOCK_50;
        end
    end

    // Reset held for the first three rising edges
    initial begin
        KEY0 <= 1'b0;
        repeat (3) @(posedge CLOCK_50);
        KEY0 <= 1'b1;
    end

endmodule

//--- design/keyboard_on_board.sv
`timescale 1ns/1ns

module keyboard_on_board
    import kbd_pkg::*;
(
    input  logic      CLOCK_50,
    input  logic      KEY0,
    input  logic      ps2_clk,
    input  logic      ps2_dat,
    input  bus_addr_t bus_address,
    input  logic      bus_read_enable,
    output bus_data_t bus_read_data,
    output irq_vec_t  interrupt_vector,
    input  logic      interrupt_ack
);
    key_event_if evt_link ();
    key_read_if  read_link ();
    err_count_t  frame_errors;

    // Keyboard frames to key events
    ps2_receiver u_ps2 (
        .CLOCK_50     (CLOCK_50),
        .KEY0         (KEY0),
        .ps2_clk      (ps2_clk),
        .ps2_dat      (ps2_dat),
        .evt          (evt_link.source),
        .frame_errors (frame_errors)
    );

    key_fifo u_fifo (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .evt      (evt_link.sink),
        .rd       (read_link.store)
    );

    // CPU side
    key_bus_port u_bus (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .rd               (read_link.reader),
        .frame_errors     (frame_errors),
        .bus_address      (bus_address),
        .bus_read_enable  (bus_read_enable),
        .bus_read_data    (bus_read_data),
        .interrupt_vector (interrupt_vector),
        .interrupt_ack    (interrupt_ack)
    );

endmodule

//--- design/key_bus_port.sv
`timescale 1ns/1ns
`include "kbd_config.svh"

module key_bus_port
    import kbd_pkg::*;
(
    input  logic        CLOCK_50,
    input  logic        KEY0,
    key_read_if.reader  rd,
    input  err_count_t  frame_errors,
    input  bus_addr_t   bus_address,
    input  logic        bus_read_enable,
    output bus_data_t   bus_read_data,
    output irq_vec_t    interrupt_vector,
    input  logic        interrupt_ack
);
    logic      data_sel;
    logic      stat_sel;
    bus_data_t key_word;
    bus_data_t stat_word;
    logic      empty_d;
    logic      became_ready;
    logic      refill;

    assign data_sel = bus_read_enable && (bus_address == `KEY_DATA_ADDR);
    assign stat_sel = bus_read_enable && (bus_address == `KEY_STAT_ADDR);

    // Pop in the cycle of the read
    assign rd.pop            = data_sel && !rd.empty;
    assign rd.clear_overflow = stat_sel;

    // Key data word, all zero when nothing is queued
    always_comb begin
        key_word = '0;
        if (!rd.empty) begin
            key_word[31]  = 1'b1;
            key_word[9]   = rd.head_extended;
            key_word[8]   = rd.head_break;
            key_word[7:0] = rd.head_code;
        end
    end

    always_comb begin
        stat_word        = '0;
        stat_word[7:0]   = 8'(rd.count);
        stat_word[8]     = rd.overflow;
        stat_word[23:16] = frame_errors;
    end

    // Read data holds until the next read
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bus_read_data <= '0;
        end else if (bus_read_enable) begin
            if (data_sel) begin
                bus_read_data <= key_word;
            end else if (stat_sel) begin
                bus_read_data <= stat_word;
            end else begin
                bus_read_data <= '0;
            end
        end
    end

    // Queue went from empty to holding a key
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            empty_d <= 1'b1;
        end else begin
            empty_d <= rd.empty;
        end
    end

    assign became_ready = empty_d && !rd.empty;
    // A data read that leaves keys behind
    assign refill = rd.pop && (rd.count > fifo_count_t'(1));

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            interrupt_vector <= '0;
        end else if ((interrupt_vector != '0) && interrupt_ack) begin
            interrupt_vector <= '0;
        end else if (became_ready || refill) begin
            interrupt_vector <= irq_vec_t'(1);
        end
    end

    // Every pop comes from a data read and returns a valid key next cycle
    a_pop_from_read: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        rd.pop |-> (bus_read_enable && (bus_address == `KEY_DATA_ADDR))
                   ##1 bus_read_data[31]);

endmodule

//--- design/key_fifo.sv
`timescale 1ns/1ns
`include "kbd_config.svh"

module key_fifo
    import kbd_pkg::*;
#(
    parameter int DEPTH = `KEY_FIFO_DEPTH
) (
    input  logic      CLOCK_50,
    input  logic      KEY0,
    key_event_if.sink evt,
    key_read_if.store rd
);
    localparam int PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int ENTRY_W = $bits(scan_code_t) + 2;

    // Entry is {extended, break, code}
    logic [ENTRY_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    fifo_count_t        count_next;
    logic               full;
    logic               do_push;
    logic               do_pop;

    assign full    = (rd.count == fifo_count_t'(DEPTH));
    assign do_pop  = rd.pop && !rd.empty;
    assign do_push = evt.strobe && !full;

    always_comb begin
        count_next = rd.count;
        if (do_push && !do_pop) begin
            count_next = rd.count + 1'b1;
        end else if (do_pop && !do_push) begin
            count_next = rd.count - 1'b1;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (do_push) begin
            mem[wr_ptr] <= {evt.is_extended, evt.is_break, evt.code};
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            rd.count    <= '0;
            rd.empty    <= 1'b1;
            rd.overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            rd.count <= count_next;
            rd.empty <= (count_next == '0);
            // Sticky until the status register is read
            if (evt.strobe && full) begin
                rd.overflow <= 1'b1;
            end else if (rd.clear_overflow) begin
                rd.overflow <= 1'b0;
            end
        end
    end

    // Oldest entry, shown without waiting for a pop
    assign {rd.head_extended, rd.head_break, rd.head_code} = mem[rd_ptr];

    a_count_bound: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        rd.count <= fifo_count_t'(DEPTH));

    a_empty_flag: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        rd.empty == (rd.count == '0));

endmodule

//--- ps2_receiver/ps2_receiver.sv
`timescale 1ns/1ns
`include "kbd_config.svh"

module ps2_receiver
    import kbd_pkg::*;
(
    input  logic        CLOCK_50,
    input  logic        KEY0,
    input  logic        ps2_clk,
    input  logic        ps2_dat,
    key_event_if.source evt,
    output err_count_t  frame_errors
);
    localparam int TIMER_W = $clog2(`PS2_IDLE_TIMEOUT + 1);
    localparam logic [TIMER_W-1:0] TIMEOUT = TIMER_W'(`PS2_IDLE_TIMEOUT);

    localparam scan_code_t CODE_EXT = 8'hE0;
    localparam scan_code_t CODE_BRK = 8'hF0;

    logic [1:0]         clk_sync;
    logic [1:0]         dat_sync;
    logic               clk_prev;
    logic               clk_fall;
    logic               dat_bit;
    ps2_state_t         state;
    logic [2:0]         bit_cnt;
    scan_code_t         shift;
    logic               parity_ok;
    logic               pend_break;
    logic               pend_ext;
    logic [TIMER_W-1:0] idle_timer;
    logic               timeout;
    logic               frame_bad;
    logic               byte_good;
    logic               key_done;

    // Lines idle high
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
            clk_prev <= clk_sync[1];
        end
    end

    assign clk_fall = clk_prev & ~clk_sync[1];
    assign dat_bit  = dat_sync[1];

    // Cycles since the last falling PS/2 clock, saturates at the timeout
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            idle_timer <= '0;
        end else if (clk_fall) begin
            idle_timer <= '0;
        end else if (idle_timer != TIMEOUT) begin
            idle_timer <= idle_timer + 1'b1;
        end
    end

    assign timeout = (state != PS2_IDLE) && !clk_fall && (idle_timer == TIMEOUT - 1'b1);

    // Bad start, bad parity or stop, or a stalled frame
    assign frame_bad = timeout ||
        (clk_fall && (state == PS2_IDLE) && dat_bit) ||
        (clk_fall && (state == PS2_STOP) && !(dat_bit && parity_ok));

    assign byte_good = clk_fall && (state == PS2_STOP) && dat_bit && parity_ok;
    assign key_done  = byte_good && (shift != CODE_EXT) && (shift != CODE_BRK);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state        <= PS2_IDLE;
            bit_cnt      <= '0;
            parity_ok    <= 1'b0;
            pend_break   <= 1'b0;
            pend_ext     <= 1'b0;
            evt.strobe   <= 1'b0;
            frame_errors <= '0;
        end else begin
            evt.strobe <= key_done;
            if (frame_bad) begin
                state      <= PS2_IDLE;
                pend_break <= 1'b0;
                pend_ext   <= 1'b0;
                if (frame_errors != 8'hFF) begin
                    frame_errors <= frame_errors + 1'b1;
                end
            end else if (clk_fall) begin
                case (state)
                    PS2_IDLE: begin
                        state   <= PS2_DATA;
                        bit_cnt <= '0;
                    end
                    PS2_DATA: begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= PS2_PARITY;
                        end
                    end
                    PS2_PARITY: begin
                        // Odd parity over data and parity bit
                        parity_ok <= ^{shift, dat_bit};
                        state     <= PS2_STOP;
                    end
                    default: begin
                        state <= PS2_IDLE;
                        if (shift == CODE_EXT) begin
                            pend_ext <= 1'b1;
                        end else if (shift == CODE_BRK) begin
                            pend_break <= 1'b1;
                        end else begin
                            pend_break <= 1'b0;
                            pend_ext   <= 1'b0;
                        end
                    end
                endcase
            end
        end
    end

    // LSB first
    always_ff @(posedge CLOCK_50) begin
        if (clk_fall && (state == PS2_DATA)) begin
            shift <= {dat_bit, shift[7:1]};
        end
        if (key_done) begin
            evt.code        <= shift;
            evt.is_break    <= pend_break;
            evt.is_extended <= pend_ext;
        end
    end

    a_strobe_single: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        evt.strobe |=> !evt.strobe);

    // A quiet PS/2 clock for the full timeout leaves the receiver idle
    a_idle_after_timeout: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (idle_timer == TIMEOUT) |-> (state == PS2_IDLE));

endmodule

//--- common/kbd_if.sv
`timescale 1ns/1ns

// Finished key from the receiver, one strobe per key
interface key_event_if
    import kbd_pkg::*;
();
    logic       strobe;
    scan_code_t code;
    logic       is_break;
    logic       is_extended;

    modport source (output strobe, output code, output is_break, output is_extended);
    modport sink (input strobe, input code, input is_break, input is_extended);
endinterface

// Queue head and status towards the bus port
interface key_read_if
    import kbd_pkg::*;
();
    logic        empty;
    fifo_count_t count;
    scan_code_t  head_code;
    logic        head_break;
    logic        head_extended;
    logic        pop;
    logic        clear_overflow;
    logic        overflow;

    modport store (
        output empty, output count, output head_code, output head_break,
        output head_extended, output overflow,
        input  pop, input clear_overflow
    );
    modport reader (
        input  empty, input count, input head_code, input head_break,
        input  head_extended, input overflow,
        output pop, output clear_overflow
    );
endinterface

//--- common/kbd_pkg.sv
`include "kbd_config.svh"

package kbd_pkg;

    // One byte from the keyboard
    typedef logic [7:0] scan_code_t;

    // Bus as seen by the CPU
    typedef logic [63:0] bus_addr_t;
    typedef logic [63:0] bus_data_t;

    // Queue occupancy, 0 up to the full depth
    typedef logic [$clog2(`KEY_FIFO_DEPTH + 1)-1:0] fifo_count_t;

    // Saturating count of rejected frames
    typedef logic [7:0] err_count_t;

    // Interrupt vector towards the CPU
    typedef logic [3:0] irq_vec_t;

    // Frame receiver
    typedef enum logic [1:0] {
        PS2_IDLE,
        PS2_DATA,
        PS2_PARITY,
        PS2_STOP
    } ps2_state_t;

endpackage

//--- common/kbd_config.svh
`ifndef KBD_CONFIG_SVH
`define KBD_CONFIG_SVH

// Memory map of the keyboard port
`define KEY_DATA_ADDR 64'h1000_0000
`define KEY_STAT_ADDR 64'h1000_0008

// Event queue size, power of two
`define KEY_FIFO_DEPTH 8

// System cycles without a PS/2 clock edge before a partial frame is dropped
`define PS2_IDLE_TIMEOUT 5000

`endif
